// ==== src/mem_pkg.sv ====
// shared widths, bus encodings and sizing for the load/store path
package mem_pkg;

	////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////

	localparam int xlen = 32;          // data and address width
	localparam int rob_tag_width = 5;  // rob entries are 32
	localparam int funct3_width = 3;   // load/store funct3 field

	// response / return tag width on the data bus
	// tag 0 is reserved and means no response
	localparam int bus_tag_width = 4;

	////////////////////////////////////////////////////////////////////
	// sizing and timing
	////////////////////////////////////////////////////////////////////

	localparam int load_buffer_depth = 4;  // entries, power of two
	localparam int mem_latency = 3;        // load accept to data return
	localparam int mem_words = 256;        // 32-bit words, 1 KiB total

	////////////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////////////

	// access size, same encoding as funct3[1:0]
	typedef enum logic [1:0] {
		mem_byte = 2'b00,    // lb / lbu / sb
		mem_half = 2'b01,    // lh / lhu / sh
		mem_word = 2'b10,    // lw / sw
		mem_double = 2'b11   // rv64 only, never produced here
	} mem_size;

	// command on the data memory bus
	typedef enum logic [1:0] {
		bus_none = 2'b00,
		bus_load = 2'b01,
		bus_store = 2'b10
	} bus_command;

endpackage

// ==== src/load_issue.sv ====
`timescale 1ns/1ps

// load issue: one register stage between dispatch and the load buffer
// computes the effective address and decodes the access size
module load_issue (
	input  logic clock,
	input  logic reset,

	// dispatch side
	input  logic dispatch_valid,
	input  logic [mem_pkg::xlen-1:0] dispatch_base,
	input  logic [mem_pkg::xlen-1:0] dispatch_offset,
	input  logic [mem_pkg::funct3_width-1:0] dispatch_funct3,
	input  logic [mem_pkg::rob_tag_width-1:0] dispatch_rob_tag,

	// toward the load buffer
	output logic issue_valid,
	output logic [mem_pkg::xlen-1:0] issue_address,
	output mem_pkg::mem_size issue_size,
	output logic issue_unsigned,
	output logic [mem_pkg::rob_tag_width-1:0] issue_rob_tag
);

	import mem_pkg::*;

	logic [xlen-1:0] effective_address;  // agu result
	mem_size decoded_size;

	// agu, plain 32-bit add, no overflow check
	assign effective_address = dispatch_base + dispatch_offset;

	// funct3[1:0] is the size, funct3[2] marks lbu/lhu
	assign decoded_size = mem_size'(dispatch_funct3[1:0]);

	////////////////////////////////////////////////////////////////////
	// issue strobe
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= dispatch_valid;  // one cycle behind dispatch
		end
	end

	////////////////////////////////////////////////////////////////////
	// payload, only loaded on a dispatch
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (dispatch_valid) begin
			issue_address <= effective_address;
			issue_size <= decoded_size;
			issue_unsigned <= dispatch_funct3[2];  // top bit = unsigned
			issue_rob_tag <= dispatch_rob_tag;
		end
	end

endmodule

// ==== src/load_buffer.sv ====
`timescale 1ns/1ps

// in-order load buffer, circular
// entries leave only from the head, when the memory stage writes back
module load_buffer #(
	parameter int depth = mem_pkg::load_buffer_depth  // power of two
) (
	input  logic clock,
	input  logic reset,

	// write side, from load issue
	input  logic issue_valid,
	input  logic [mem_pkg::xlen-1:0] issue_address,
	input  mem_pkg::mem_size issue_size,
	input  logic issue_unsigned,
	input  logic [mem_pkg::rob_tag_width-1:0] issue_rob_tag,

	// read side, to the memory stage
	input  logic pop,
	output logic head_valid,
	output logic [mem_pkg::xlen-1:0] head_address,
	output mem_pkg::mem_size head_size,
	output logic head_unsigned,
	output logic [mem_pkg::rob_tag_width-1:0] head_rob_tag,

	output logic full  // level, back-pressure to dispatch
);

	import mem_pkg::*;

	localparam int pointer_width = (depth > 1) ? $clog2(depth) : 1;

	// entry storage, no reset needed
	logic [xlen-1:0] address_q [depth];
	mem_size size_q [depth];
	logic unsigned_q [depth];
	logic [rob_tag_width-1:0] rob_tag_q [depth];

	logic [pointer_width-1:0] head_pointer;  // oldest load
	logic [pointer_width-1:0] tail_pointer;  // next free slot
	logic [pointer_width:0] count;           // 0 .. depth

	////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head_pointer <= '0;
			tail_pointer <= '0;
			count <= '0;
		end else begin
			if (issue_valid)
				tail_pointer <= tail_pointer + 1'b1;  // wraps at depth
			if (pop)
				head_pointer <= head_pointer + 1'b1;
			// push and pop in the same cycle cancel out
			case ({issue_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// entry write at the tail
	always_ff @(posedge clock) begin
		if (issue_valid) begin
			address_q[tail_pointer] <= issue_address;
			size_q[tail_pointer] <= issue_size;
			unsigned_q[tail_pointer] <= issue_unsigned;
			rob_tag_q[tail_pointer] <= issue_rob_tag;
		end
	end

	////////////////////////////////////////////////////////////////////
	// head view and full level
	////////////////////////////////////////////////////////////////////

	assign head_valid = (count != '0);
	assign head_address = address_q[head_pointer];
	assign head_size = size_q[head_pointer];
	assign head_unsigned = unsigned_q[head_pointer];
	assign head_rob_tag = rob_tag_q[head_pointer];

	// issue_valid is the load sitting in load_issue, it lands next edge
	// counting it here means an accepted dispatch always has a slot
	assign full = (count + issue_valid) >= depth;

endmodule

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps

// memory access stage
// stores from commit always win the bus, loads leave from the buffer head
// one load outstanding at a time, matched by its response tag
module mem_stage (
	input  logic clock,
	input  logic reset,

	// head of the load buffer
	input  logic head_valid,
	input  logic [mem_pkg::xlen-1:0] head_address,
	input  mem_pkg::mem_size head_size,
	input  logic head_unsigned,
	input  logic [mem_pkg::rob_tag_width-1:0] head_rob_tag,
	output logic pop,

	// committed stores
	input  logic commit_valid,
	input  logic [mem_pkg::xlen-1:0] commit_address,
	input  logic [mem_pkg::xlen-1:0] commit_data,
	input  logic [mem_pkg::funct3_width-1:0] commit_funct3,

	// data memory bus
	output mem_pkg::bus_command mem_command,
	output logic [mem_pkg::xlen-1:0] mem_address,
	output mem_pkg::mem_size mem_size,
	output logic [mem_pkg::xlen-1:0] mem_store_data,
	input  logic [mem_pkg::bus_tag_width-1:0] mem_response,
	input  logic [mem_pkg::bus_tag_width-1:0] mem_tag,
	input  logic [mem_pkg::xlen-1:0] mem_data,

	// writeback
	output logic wb_valid,
	output logic [mem_pkg::rob_tag_width-1:0] wb_rob_tag,
	output logic [mem_pkg::xlen-1:0] wb_value
);

	import mem_pkg::*;

	typedef enum logic {
		state_ready,     // free to send a load
		state_mem_wait   // load out, watching mem_tag
	} stage_state;

	stage_state state;
	stage_state next_state;
	logic [bus_tag_width-1:0] recorded_response;  // tag of the load in flight
	logic load_done;                              // matching tag came back
	logic [xlen-1:0] lane_data;                   // mem_data moved to bit 0

	////////////////////////////////////////////////////////////////////
	// bus command selection
	////////////////////////////////////////////////////////////////////

	always_comb begin
		if (commit_valid)
			mem_command = bus_store;  // never stalled
		else if (head_valid && state == state_ready)
			mem_command = bus_load;
		else
			mem_command = bus_none;
	end

	// address, size and data follow whichever command won
	always_comb begin
		case (mem_command)
			bus_store: begin
				mem_address = commit_address;
				mem_size = mem_pkg::mem_size'(commit_funct3[1:0]);  // sb/sh/sw
				mem_store_data = commit_data;
			end
			bus_load: begin
				mem_address = head_address;
				mem_size = head_size;
				mem_store_data = '0;
			end
			default: begin
				mem_address = '0;
				mem_size = mem_word;
				mem_store_data = '0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////
	// response tracking
	////////////////////////////////////////////////////////////////////

	// tag 0 never matches, it means nothing returned
	assign load_done = (state == state_mem_wait) && (recorded_response != '0) &&
		(mem_tag == recorded_response);

	always_comb begin
		next_state = state;
		case (state)
			state_ready:
				if (mem_command == bus_load)
					next_state = state_mem_wait;  // memory always accepts
			state_mem_wait:
				if (load_done)
					next_state = state_ready;
			default:
				next_state = state_ready;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= state_ready;
			recorded_response <= '0;
		end else begin
			state <= next_state;
			if (mem_command == bus_load)
				recorded_response <= mem_response;  // same-cycle tag
		end
	end

	////////////////////////////////////////////////////////////////////
	// writeback and extension
	////////////////////////////////////////////////////////////////////

	assign wb_valid = load_done;
	assign pop = load_done;          // head retires with its writeback
	assign wb_rob_tag = head_rob_tag;

	// pick the addressed byte / half down to the low bits
	assign lane_data = mem_data >> {head_address[1:0], 3'b000};

	always_comb begin
		case (head_size)
			mem_byte:
				wb_value = head_unsigned ? {{(xlen - 8){1'b0}}, lane_data[7:0]}
					: {{(xlen - 8){lane_data[7]}}, lane_data[7:0]};
			mem_half:
				wb_value = head_unsigned ? {{(xlen - 16){1'b0}}, lane_data[15:0]}
					: {{(xlen - 16){lane_data[15]}}, lane_data[15:0]};
			default:
				wb_value = mem_data;  // word, no extension
		endcase
	end

endmodule

// ==== src/data_memory.sv ====
`timescale 1ns/1ps

// tagged data memory model
// loads get a nonzero tag right away, data comes back mem_latency later
module data_memory (
	input  logic clock,
	input  logic reset,

	// request side
	input  mem_pkg::bus_command mem_command,
	input  logic [mem_pkg::xlen-1:0] mem_address,
	input  mem_pkg::mem_size mem_size,
	input  logic [mem_pkg::xlen-1:0] mem_store_data,

	// response side
	output logic [mem_pkg::bus_tag_width-1:0] mem_response,
	output logic [mem_pkg::bus_tag_width-1:0] mem_tag,
	output logic [mem_pkg::xlen-1:0] mem_data
);

	import mem_pkg::*;

	logic [xlen-1:0] memory_array [mem_words];  // word array, no reset

	logic [$clog2(mem_words)-1:0] word_index;
	logic [xlen/8-1:0] lane_enable;     // byte write enables
	logic [xlen-1:0] store_shifted;     // store data in its lanes
	logic load_accept;
	logic [bus_tag_width-1:0] next_tag;  // rotates 1..15

	// return pipeline, stage 0 captures at the accept edge
	logic [bus_tag_width-1:0] tag_pipe [mem_latency];
	logic [xlen-1:0] data_pipe [mem_latency];

	assign word_index = mem_address[$clog2(mem_words)+1:2];  // bits 9:2
	assign load_accept = (mem_command == bus_load);

	// tag handed back in the same cycle, 0 for store / idle
	assign mem_response = load_accept ? next_tag : '0;

	////////////////////////////////////////////////////////////////////
	// store lanes
	////////////////////////////////////////////////////////////////////

	always_comb begin
		case (mem_size)
			mem_byte: lane_enable = 4'b0001 << mem_address[1:0];
			mem_half: lane_enable = 4'b0011 << mem_address[1:0];  // aligned only
			default: lane_enable = 4'b1111;
		endcase
	end

	assign store_shifted = mem_store_data << {mem_address[1:0], 3'b000};

	always_ff @(posedge clock) begin
		if (mem_command == bus_store) begin
			for (int lane = 0; lane < xlen / 8; lane++) begin
				if (lane_enable[lane])
					memory_array[word_index][lane*8 +: 8] <= store_shifted[lane*8 +: 8];
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// tag counter and return pipeline
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			next_tag <= 1;
			for (int stage = 0; stage < mem_latency; stage++)
				tag_pipe[stage] <= '0;
		end else begin
			if (load_accept)
				next_tag <= (next_tag == '1) ? 1 : next_tag + 1'b1;  // skip 0
			tag_pipe[0] <= mem_response;
			for (int stage = 1; stage < mem_latency; stage++)
				tag_pipe[stage] <= tag_pipe[stage-1];
		end
	end

	// read word taken at accept time, just rides along with its tag
	always_ff @(posedge clock) begin
		data_pipe[0] <= memory_array[word_index];
		for (int stage = 1; stage < mem_latency; stage++)
			data_pipe[stage] <= data_pipe[stage-1];
	end

	assign mem_tag = tag_pipe[mem_latency-1];   // 0 when nothing returns
	assign mem_data = data_pipe[mem_latency-1];

endmodule

// ==== src/mem_subsystem.sv ====
`timescale 1ns/1ps

// load/store path top: issue -> buffer -> mem stage <-> data memory
module mem_subsystem (
	input  logic clock,
	input  logic reset,

	// load dispatch
	input  logic dispatch_valid,
	input  logic [mem_pkg::xlen-1:0] dispatch_base,
	input  logic [mem_pkg::xlen-1:0] dispatch_offset,
	input  logic [mem_pkg::funct3_width-1:0] dispatch_funct3,
	input  logic [mem_pkg::rob_tag_width-1:0] dispatch_rob_tag,
	output logic dispatch_ready,

	// store commit
	input  logic commit_valid,
	input  logic [mem_pkg::xlen-1:0] commit_address,
	input  logic [mem_pkg::xlen-1:0] commit_data,
	input  logic [mem_pkg::funct3_width-1:0] commit_funct3,

	// load writeback
	output logic wb_valid,
	output logic [mem_pkg::rob_tag_width-1:0] wb_rob_tag,
	output logic [mem_pkg::xlen-1:0] wb_value
);

	import mem_pkg::*;

	////////////////////////////////////////////////////////////////////
	// interconnect
	////////////////////////////////////////////////////////////////////

	logic issue_valid;
	logic [xlen-1:0] issue_address;
	mem_size issue_size;
	logic issue_unsigned;
	logic [rob_tag_width-1:0] issue_rob_tag;

	logic head_valid;
	logic [xlen-1:0] head_address;
	mem_size head_size;
	logic head_unsigned;
	logic [rob_tag_width-1:0] head_rob_tag;
	logic pop;
	logic full;

	bus_command mem_command;        // mem stage -> memory
	logic [xlen-1:0] mem_address;
	mem_size mem_size_sel;
	logic [xlen-1:0] mem_store_data;
	logic [bus_tag_width-1:0] mem_response;  // memory -> mem stage
	logic [bus_tag_width-1:0] mem_tag;
	logic [xlen-1:0] mem_data;

	assign dispatch_ready = ~full;  // only back-pressure in the path

	////////////////////////////////////////////////////////////////////
	// instances
	////////////////////////////////////////////////////////////////////

	load_issue load_issue_i (
		.clock, .reset,
		.dispatch_valid, .dispatch_base, .dispatch_offset, .dispatch_funct3, .dispatch_rob_tag,
		.issue_valid, .issue_address, .issue_size, .issue_unsigned, .issue_rob_tag
	);

	load_buffer #(.depth(load_buffer_depth)) load_buffer_i (
		.clock, .reset,
		.issue_valid, .issue_address, .issue_size, .issue_unsigned, .issue_rob_tag,
		.pop, .head_valid, .head_address, .head_size, .head_unsigned, .head_rob_tag,
		.full
	);

	mem_stage mem_stage_i (
		.clock, .reset,
		.head_valid, .head_address, .head_size, .head_unsigned, .head_rob_tag, .pop,
		.commit_valid, .commit_address, .commit_data, .commit_funct3,
		.mem_command, .mem_address, .mem_size(mem_size_sel), .mem_store_data,
		.mem_response, .mem_tag, .mem_data,
		.wb_valid, .wb_rob_tag, .wb_value
	);

	data_memory data_memory_i (
		.clock, .reset,
		.mem_command, .mem_address, .mem_size(mem_size_sel), .mem_store_data,
		.mem_response, .mem_tag, .mem_data
	);

endmodule

// ==== sim/mem_subsystem_tb.sv ====
`timescale 1ns/1ps

module mem_subsystem_tb;

	import mem_pkg::*;

	localparam int timeout_cycles = 50;

	logic clock;
	logic reset;
	logic dispatch_valid;
	logic [xlen-1:0] dispatch_base;
	logic [xlen-1:0] dispatch_offset;
	logic [funct3_width-1:0] dispatch_funct3;
	logic [rob_tag_width-1:0] dispatch_rob_tag;
	logic dispatch_ready;
	logic commit_valid;
	logic [xlen-1:0] commit_address;
	logic [xlen-1:0] commit_data;
	logic [funct3_width-1:0] commit_funct3;
	logic wb_valid;
	logic [rob_tag_width-1:0] wb_rob_tag;
	logic [xlen-1:0] wb_value;

	integer seed;
	logic [7:0] mirror [mem_words*4];               // byte image of the memory
	logic [rob_tag_width-1:0] expected_tags [$];    // oldest load first
	logic [xlen-1:0] expected_values [$];
	logic [rob_tag_width-1:0] next_rob_tag;
	logic [2:0] load_kinds [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};  // lb lh lw lbu lhu

	mem_subsystem dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	task automatic report_failure(input string message);
		$display("%s", message);
		$display("Simulation failed");
		$fatal(1);
	endtask

	function automatic string mismatch_text(input string name, input logic [xlen-1:0] expected,
		input logic [xlen-1:0] actual);
		return $sformatf("CHECK FAILED %s: expected 0x%0h, got 0x%0h", name, expected, actual);
	endfunction

	// aligned byte address, lower half for loads, upper half for stores
	function automatic logic [9:0] random_address(input logic [1:0] size, input logic upper);
		logic [9:0] address;
		address = $random(seed);
		address[9] = upper;
		return address & ~((10'd1 << size) - 10'd1);
	endfunction

	// load result straight from the mirror, little endian
	function automatic logic [xlen-1:0] expected_load_value(input logic [9:0] address,
		input logic [2:0] funct3);
		logic [15:0] half;
		half = {mirror[address + 1], mirror[address]};
		case (funct3[1:0])
			2'b00: return funct3[2] ? {24'b0, mirror[address]}
				: {{24{mirror[address][7]}}, mirror[address]};
			2'b01: return funct3[2] ? {16'b0, half} : {{16{half[15]}}, half};
			default: return {mirror[address + 3], mirror[address + 2], half};
		endcase
	endfunction

	task automatic idle_inputs;
		dispatch_valid <= 1'b0;
		commit_valid <= 1'b0;
	endtask

	task automatic next_cycle;
		@(posedge clock);
		idle_inputs();  // later puts in this step override
	endtask

	task automatic put_load(input logic [9:0] address, input logic [2:0] funct3);
		logic [xlen-1:0] offset;
		offset = $random(seed);
		dispatch_valid <= 1'b1;
		dispatch_offset <= offset;
		dispatch_base <= xlen'(address) - offset;  // base + offset wraps onto address
		dispatch_funct3 <= funct3;
		dispatch_rob_tag <= next_rob_tag;
		expected_tags.push_back(next_rob_tag);
		expected_values.push_back(expected_load_value(address, funct3));
		next_rob_tag = next_rob_tag + 1'b1;
	endtask

	task automatic put_store(input logic [9:0] address, input logic [xlen-1:0] data,
		input logic [2:0] funct3);
		commit_valid <= 1'b1;
		commit_address <= xlen'(address);
		commit_data <= data;
		commit_funct3 <= funct3;
		for (int b = 0; b < (1 << funct3[1:0]); b++)
			mirror[address + b] = data[b*8 +: 8];  // low bytes land at address
	endtask

	// returns at the edge where a dispatch may be driven
	task automatic wait_dispatch_ready;
		int waited;
		waited = 0;
		@(negedge clock);
		while (!dispatch_ready) begin
			waited++;
			if (waited > timeout_cycles)
				report_failure("timeout waiting for dispatch_ready");
			@(negedge clock);
		end
		next_cycle();
	endtask

	task automatic wait_writeback_pulse(output int cycles);
		cycles = 0;
		do begin
			next_cycle();
			@(negedge clock);
			cycles++;
			if (cycles > timeout_cycles)
				report_failure("timeout waiting for wb_valid");
		end while (!wb_valid);
	endtask

	task automatic wait_for_writebacks;
		int waited;
		waited = 0;
		while (expected_tags.size() != 0) begin
			waited++;
			if (waited > timeout_cycles)
				report_failure("timeout with loads still waiting for writeback");
			next_cycle();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// checkers
	//////////////////////////////////////////////////////////////////////

	// writebacks must come back in dispatch order
	always @(negedge clock) begin
		if (!reset && wb_valid) begin
			assert (expected_tags.size() != 0)
				else report_failure("wb_valid seen with no load pending");
			assert (wb_rob_tag == expected_tags[0])
				else report_failure(mismatch_text("wb_rob_tag", expected_tags[0], wb_rob_tag));
			assert (wb_value == expected_values[0])
				else report_failure(mismatch_text("wb_value", expected_values[0], wb_value));
			void'(expected_tags.pop_front());
			void'(expected_values.pop_front());
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		dut_i.issue_valid |-> dut_i.issue_size != mem_double)
		else report_failure($sformatf("CHECK FAILED issue_size: doubleword issued, got 0x%0h",
			dut_i.issue_size));

	assert property (@(posedge clock) disable iff (reset) !$isunknown({wb_valid, dispatch_ready}))
		else report_failure("wb_valid or dispatch_ready went unknown");

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		int latency;
		logic [9:0] address;
		logic [xlen-1:0] data;
		logic [2:0] funct3;
		logic [1:0] store_size;
		seed = 32'hbd3d;
		reset = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_base = '0;
		dispatch_offset = '0;
		dispatch_funct3 = '0;
		dispatch_rob_tag = '0;
		commit_valid = 1'b0;
		commit_address = '0;
		commit_data = '0;
		commit_funct3 = '0;
		next_rob_tag = '0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		assert (!wb_valid) else report_failure(mismatch_text("wb_valid", 0, wb_valid));
		assert (dispatch_ready) else report_failure(mismatch_text("dispatch_ready", 1, 0));

		// every word gets known data first
		for (int word = 0; word < mem_words; word++) begin
			next_cycle();
			put_store(10'(word * 4), $random(seed), 3'b010);
		end

		// store then load, each size, negative then positive bytes
		for (int rep = 0; rep < 2; rep++) begin
			for (int kind = 0; kind < 5; kind++) begin
				funct3 = load_kinds[kind];
				address = random_address(funct3[1:0], 1'b0);
				data = $random(seed);
				data = (rep == 0) ? (data | 32'h80808080) : (data & 32'h7f7f7f7f);
				next_cycle();
				put_store(address, data, {1'b0, funct3[1:0]});
				wait_dispatch_ready();
				put_load(address, funct3);
				wait_for_writebacks();
			end
		end

		// idle path latency, issue + buffer + memory
		wait_dispatch_ready();
		put_load(random_address(2'b10, 1'b0), 3'b010);
		wait_writeback_pulse(latency);
		assert (latency == 2 + mem_latency)
			else report_failure(mismatch_text("wb_valid latency", 2 + mem_latency, latency));
		wait_for_writebacks();

		// back-to-back loads
		for (int load = 0; load < 3; load++) begin
			funct3 = load_kinds[$unsigned($random(seed)) % 5];
			wait_dispatch_ready();
			put_load(random_address(funct3[1:0], 1'b0), funct3);
		end
		wait_for_writebacks();

		// store every cycle while loads queue up
		for (int cycle = 0; cycle < 12; cycle++) begin
			funct3 = load_kinds[$unsigned($random(seed)) % 5];
			store_size = 2'($unsigned($random(seed)) % 3);
			if (cycle < load_buffer_depth) begin
				wait_dispatch_ready();
				put_load(random_address(funct3[1:0], 1'b0), funct3);
			end else begin
				next_cycle();
			end
			put_store(random_address(store_size, 1'b1), $random(seed), {1'b0, store_size});
		end
		wait_for_writebacks();

		// commit held high, nothing leaves, buffer fills
		address = random_address(2'b10, 1'b1);
		data = $random(seed);
		for (int load = 0; load < load_buffer_depth; load++) begin
			next_cycle();
			put_store(address, data, 3'b010);
			@(negedge clock);
			assert (dispatch_ready) else report_failure(mismatch_text("dispatch_ready", 1, 0));
			next_cycle();
			put_store(address, data, 3'b010);
			funct3 = load_kinds[$unsigned($random(seed)) % 5];
			put_load(random_address(funct3[1:0], 1'b0), funct3);
		end
		next_cycle();
		put_store(address, data, 3'b010);
		@(negedge clock);
		assert (!dispatch_ready) else report_failure(mismatch_text("dispatch_ready", 0, 1));
		wait_writeback_pulse(latency);  // commit released here
		@(negedge clock);
		assert (dispatch_ready) else report_failure(mismatch_text("dispatch_ready", 1, 0));
		wait_for_writebacks();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== mem_subsystem.f ====
src/mem_pkg.sv
src/load_issue.sv
src/load_buffer.sv
src/mem_stage.sv
src/data_memory.sv
src/mem_subsystem.sv
sim/mem_subsystem_tb.sv
